//--- Makefile
TOP = exec_core_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Simulation passed" > /dev/null

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import exec_pkg::*;
(
    input  wire logic [31:0] a,
    input  wire logic [31:0] b,
    input  wire alu_op_t     alu_op,
    input  wire logic        carry_in,      // current C flag
    input  wire logic        shift_carry,
    input  wire logic [3:0]  flags_in,      // nzcv
    output logic      [31:0] result,
    output logic      [3:0]  flags_out
);

    logic [32:0] sum;
    logic [32:0] diff;
    logic        c;
    logic        v;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + 33'd1;   // bit 32 set means no borrow

    always_comb begin
        c = shift_carry;    // logic ops and moves take the shifter carry
        v = flags_in[0];    // and keep V
        case (alu_op)
            ALU_ADD: begin
                result = sum[31:0];
                c      = sum[32];
                v      = (a[31] == b[31]) && (sum[31] != a[31]);
            end
            ALU_SUB: begin
                result = diff[31:0];
                c      = diff[32];
                v      = (a[31] != b[31]) && (diff[31] != a[31]);
            end
            ALU_AND:    result = a & b;
            ALU_ORR:    result = a | b;
            ALU_EOR:    result = a ^ b;
            ALU_PASS_B: result = b;
            ALU_NOT_B:  result = ~b;
            default: begin
                result = '0;
                c      = carry_in;  // unused code, flags hold
            end
        endcase
        flags_out = {result[31], result == 32'd0, c, v};
    end

endmodule

`default_nettype wire

//--- logic/barrel_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module barrel_shifter
    import exec_pkg::*;
(
    input  wire logic [31:0] value,
    input  wire shift_op_t   shift_op,
    input  wire logic [4:0]  amount,
    input  wire logic        carry_in,
    output logic      [31:0] result,
    output logic             carry_out
);

    logic [5:0] inv_amt;    // 32 - amount, for lsl carry and ror wrap

    assign inv_amt = 6'd32 - {1'b0, amount};

    always_comb begin
        result    = value;
        carry_out = carry_in;
        if (amount != 5'd0) begin
            case (shift_op)
                SH_LSL: begin
                    result    = value << amount;
                    carry_out = value[inv_amt[4:0]];  // last bit shifted out the top
                end
                SH_LSR: begin
                    result    = value >> amount;
                    carry_out = value[amount - 5'd1];
                end
                SH_ASR: begin
                    result    = $unsigned($signed(value) >>> amount);
                    carry_out = value[amount - 5'd1];
                end
                default: begin  // ror
                    result    = (value >> amount) | (value << inv_amt);
                    carry_out = value[amount - 5'd1];
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath
    import exec_pkg::*;
#(
    parameter int PC_WIDTH = 11,
    parameter int START_PC = 0
) (
    input  wire logic        clk,
    input  wire logic        rst,
    // register addresses
    input  wire logic [3:0]  a_addr,
    input  wire logic [3:0]  b_addr,
    input  wire logic [3:0]  s_addr,
    input  wire logic [3:0]  w_addr,
    // capture and write enables
    input  wire logic        en_a,
    input  wire logic        en_b,
    input  wire logic        en_s,
    input  wire logic        w_en,
    input  wire logic        en_status,
    // operand and pc controls
    input  wire logic        sel_a_pc,
    input  wire logic        sel_imm,
    input  wire logic        sel_branch_imm,
    input  wire logic        sel_shift_reg,
    input  wire logic        load_branch,
    input  wire logic        step_pc,
    // command fields
    input  wire shift_op_t   shift_op,
    input  wire logic [4:0]  shamt,
    input  wire logic [13:0] imm14,
    input  wire alu_op_t     alu_op,
    // host port
    input  wire logic [3:0]  host_addr,
    input  wire logic        host_w_en,
    input  wire logic [31:0] host_w_data,
    // read back
    output logic      [31:0] host_r_data,
    output logic      [3:0]  status_out,
    output logic      [31:0] pc
);

    logic [31:0]         a_data;
    logic [31:0]         b_data;
    logic [31:0]         s_data;
    logic [PC_WIDTH-1:0] rf_pc;

    logic [31:0] a_q;
    logic [31:0] b_q;
    logic [4:0]  s_q;
    logic [3:0]  status_q;     // nzcv

    logic [31:0] imm_ext;
    logic [31:0] sh_result;
    logic        sh_carry;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic [3:0]  alu_flags;

    regfile #(
        .PC_WIDTH (PC_WIDTH),
        .START_PC (START_PC)
    ) u_regfile (
        .clk           (clk),
        .rst           (rst),
        .w_addr        (w_addr),
        .w_data        (alu_result),
        .w_en          (w_en),
        .host_addr     (host_addr),
        .host_w_data   (host_w_data),
        .host_w_en     (host_w_en),
        .a_addr        (a_addr),
        .b_addr        (b_addr),
        .s_addr        (s_addr),
        .a_data        (a_data),
        .b_data        (b_data),
        .s_data        (s_data),
        .host_r_data   (host_r_data),
        .pc            (rf_pc),
        .load_branch   (load_branch),
        .step_pc       (step_pc),
        .branch_target (alu_result[PC_WIDTH-1:0])   // pc + offset from the adder
    );

    barrel_shifter u_barrel_shifter (
        .value     (b_q),
        .shift_op  (shift_op),
        .amount    (s_q),
        .carry_in  (status_q[1]),
        .result    (sh_result),
        .carry_out (sh_carry)
    );

    alu u_alu (
        .a           (a_q),
        .b           (alu_b),
        .alu_op      (alu_op),
        .carry_in    (status_q[1]),
        .shift_carry (sh_carry),
        .flags_in    (status_q),
        .result      (alu_result),
        .flags_out   (alu_flags)
    );

    assign pc = {{(32 - PC_WIDTH){1'b0}}, rf_pc};

    // branch offsets are signed, data immediates are not
    assign imm_ext = sel_branch_imm ? {{18{imm14[13]}}, imm14} : {18'd0, imm14};
    assign alu_b   = sel_imm ? imm_ext : sh_result;

    // operand registers
    always_ff @(posedge clk) begin
        if (en_a) begin
            a_q <= sel_a_pc ? pc : a_data;
        end
        if (en_b) begin
            b_q <= b_data;
        end
        if (en_s) begin
            s_q <= sel_shift_reg ? s_data[4:0] : shamt;    // low 5 bits of rs
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
        end else if (en_status) begin
            status_q <= alu_flags;
        end
    end

    assign status_out = status_q;

endmodule

`default_nettype wire

//--- logic/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core
    import exec_pkg::*;
#(
    parameter int PC_WIDTH = 11,
    parameter int START_PC = 0
) (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        cyc,
    input  wire logic        stb,
    input  wire logic        we,
    input  wire logic [6:0]  adr,
    input  wire logic [31:0] dat_w,
    input  wire logic [3:0]  sel,   // full-word accesses only
    output logic      [31:0] dat_r,
    output logic             ack
);

    logic [3:0]  a_addr;
    logic [3:0]  b_addr;
    logic [3:0]  s_addr;
    logic [3:0]  w_addr;
    logic        en_a;
    logic        en_b;
    logic        en_s;
    logic        w_en;
    logic        en_status;
    logic        sel_a_pc;
    logic        sel_imm;
    logic        sel_branch_imm;
    logic        sel_shift_reg;
    logic        load_branch;
    logic        step_pc;
    shift_op_t   shift_op;
    logic [4:0]  shamt;
    logic [13:0] imm14;
    alu_op_t     alu_op;
    logic [3:0]  host_addr;
    logic        host_w_en;
    logic [31:0] host_w_data;
    logic [31:0] host_r_data;
    logic [3:0]  status_out;
    logic [31:0] pc;

    exec_ctrl u_exec_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cyc            (cyc),
        .stb            (stb),
        .we             (we),
        .adr            (adr),
        .dat_w          (dat_w),
        .dat_r          (dat_r),
        .ack            (ack),
        .a_addr         (a_addr),
        .b_addr         (b_addr),
        .s_addr         (s_addr),
        .w_addr         (w_addr),
        .en_a           (en_a),
        .en_b           (en_b),
        .en_s           (en_s),
        .w_en           (w_en),
        .en_status      (en_status),
        .sel_a_pc       (sel_a_pc),
        .sel_imm        (sel_imm),
        .sel_branch_imm (sel_branch_imm),
        .sel_shift_reg  (sel_shift_reg),
        .load_branch    (load_branch),
        .step_pc        (step_pc),
        .shift_op       (shift_op),
        .shamt          (shamt),
        .imm14          (imm14),
        .alu_op         (alu_op),
        .host_addr      (host_addr),
        .host_w_en      (host_w_en),
        .host_w_data    (host_w_data),
        .host_r_data    (host_r_data),
        .status_out     (status_out),
        .pc             (pc)
    );

    datapath #(
        .PC_WIDTH (PC_WIDTH),
        .START_PC (START_PC)
    ) u_datapath (
        .clk            (clk),
        .rst            (rst),
        .a_addr         (a_addr),
        .b_addr         (b_addr),
        .s_addr         (s_addr),
        .w_addr         (w_addr),
        .en_a           (en_a),
        .en_b           (en_b),
        .en_s           (en_s),
        .w_en           (w_en),
        .en_status      (en_status),
        .sel_a_pc       (sel_a_pc),
        .sel_imm        (sel_imm),
        .sel_branch_imm (sel_branch_imm),
        .sel_shift_reg  (sel_shift_reg),
        .load_branch    (load_branch),
        .step_pc        (step_pc),
        .shift_op       (shift_op),
        .shamt          (shamt),
        .imm14          (imm14),
        .alu_op         (alu_op),
        .host_addr      (host_addr),
        .host_w_en      (host_w_en),
        .host_w_data    (host_w_data),
        .host_r_data    (host_r_data),
        .status_out     (status_out),
        .pc             (pc)
    );

endmodule

`default_nettype wire

//--- logic/exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl
    import exec_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    // wishbone slave
    input  wire logic        cyc,
    input  wire logic        stb,
    input  wire logic        we,
    input  wire logic [6:0]  adr,
    input  wire logic [31:0] dat_w,
    output logic      [31:0] dat_r,
    output logic             ack,
    // datapath control
    output logic      [3:0]  a_addr,
    output logic      [3:0]  b_addr,
    output logic      [3:0]  s_addr,
    output logic      [3:0]  w_addr,
    output logic             en_a,
    output logic             en_b,
    output logic             en_s,
    output logic             w_en,
    output logic             en_status,
    output logic             sel_a_pc,
    output logic             sel_imm,
    output logic             sel_branch_imm,
    output logic             sel_shift_reg,
    output logic             load_branch,
    output logic             step_pc,
    output shift_op_t        shift_op,
    output logic      [4:0]  shamt,
    output logic      [13:0] imm14,
    output alu_op_t          alu_op,
    output logic      [3:0]  host_addr,
    output logic             host_w_en,
    output logic      [31:0] host_w_data,
    // datapath read back
    input  wire logic [31:0] host_r_data,
    input  wire logic [3:0]  status_out,
    input  wire logic [31:0] pc
);

    typedef enum logic [1:0] {IDLE, LOAD, EXEC, DONE} state_t;

    state_t      state;
    logic [31:0] cmd_q;
    logic [4:0]  word;
    logic        req;
    logic        cmd_start;
    logic        acc_start;
    logic        is_reg_word;
    logic [3:0]  opcode;
    logic        imm_sel;
    logic        is_branch;
    logic        is_alu;        // ops 0..6 write rd

    assign word        = adr[6:2];
    assign req         = cyc & stb & ~ack;  // held stb after ack starts nothing
    assign cmd_start   = (state == IDLE) & req & we & (word == ADR_CMD);
    assign acc_start   = (state == IDLE) & req & ~cmd_start;
    assign is_reg_word = word >= ADR_REG_BASE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            ack   <= 1'b0;
        end else begin
            ack <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_start) begin
                        state <= LOAD;
                    end else if (acc_start) begin
                        ack <= 1'b1;    // register and status words, one cycle
                    end
                end
                LOAD: state <= EXEC;
                EXEC: begin
                    state <= DONE;
                    ack   <= 1'b1;
                end
                default: state <= IDLE;     // DONE, ack drops here
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start) begin
            cmd_q <= dat_w;
        end
    end

    // command decode
    assign opcode    = cmd_q[OPCODE_MSB:OPCODE_LSB];
    assign imm_sel   = cmd_q[IMM_SEL_BIT];
    assign is_branch = opcode == OP_B;
    assign is_alu    = opcode <= OP_MVN;

    assign a_addr   = cmd_q[RN_MSB:RN_LSB];
    assign b_addr   = cmd_q[RM_MSB:RM_LSB];
    assign s_addr   = cmd_q[RS_MSB:RS_LSB];
    assign w_addr   = cmd_q[RD_MSB:RD_LSB];
    assign imm14    = cmd_q[IMM14_MSB:IMM14_LSB];
    assign shift_op = shift_op_t'(cmd_q[SHIFT_OP_MSB:SHIFT_OP_LSB]);
    // zero amount for immediates, so the shifter hands back the old C
    assign shamt    = imm_sel ? 5'd0 : cmd_q[SHAMT_MSB:SHAMT_LSB];

    assign sel_a_pc       = is_branch;
    assign sel_imm        = imm_sel | is_branch;
    assign sel_branch_imm = is_branch;
    assign sel_shift_reg  = ~imm_sel & cmd_q[SHIFT_BY_REG_BIT];

    always_comb begin
        case (opcode)
            OP_SUB, OP_CMP: alu_op = ALU_SUB;
            OP_AND:         alu_op = ALU_AND;
            OP_ORR:         alu_op = ALU_ORR;
            OP_EOR:         alu_op = ALU_EOR;
            OP_MOV:         alu_op = ALU_PASS_B;
            OP_MVN:         alu_op = ALU_NOT_B;
            default:        alu_op = ALU_ADD;  // add, and pc + offset for branches
        endcase
    end

    assign en_a        = state == LOAD;
    assign en_b        = state == LOAD;
    assign en_s        = state == LOAD;
    assign w_en        = (state == EXEC) & is_alu;
    assign en_status   = (state == EXEC) & ((cmd_q[SET_FLAGS_BIT] & is_alu) | (opcode == OP_CMP));
    assign load_branch = (state == EXEC) & is_branch;
    assign step_pc     = (state == EXEC) & ~is_branch;     // no-ops still advance

    // host register access
    assign host_addr   = word[3:0];
    assign host_w_en   = acc_start & we & is_reg_word;
    assign host_w_data = dat_w;

    always_comb begin
        if (is_reg_word) begin
            dat_r = host_r_data;
        end else if (word == ADR_STATUS) begin
            dat_r = {status_out, 28'd0};
        end else if (word == ADR_PC) begin
            dat_r = pc;
        end else begin
            dat_r = '0;     // cmd and unmapped words
        end
    end

endmodule

`default_nettype wire

//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // command word field positions
    localparam int OPCODE_MSB       = 31;
    localparam int OPCODE_LSB       = 28;
    localparam int SET_FLAGS_BIT    = 27;
    localparam int IMM_SEL_BIT      = 26;
    localparam int RD_MSB           = 25;
    localparam int RD_LSB           = 22;
    localparam int RN_MSB           = 21;
    localparam int RN_LSB           = 18;
    localparam int RM_MSB           = 17;
    localparam int RM_LSB           = 14;
    localparam int IMM14_MSB        = 13;
    localparam int IMM14_LSB        = 0;
    localparam int SHIFT_OP_MSB     = 13;   // overlaps imm14
    localparam int SHIFT_OP_LSB     = 12;
    localparam int SHIFT_BY_REG_BIT = 11;
    localparam int SHAMT_MSB        = 10;
    localparam int SHAMT_LSB        = 6;
    localparam int RS_MSB           = 9;    // shares bits with shamt
    localparam int RS_LSB           = 6;

    localparam logic [3:0] OP_ADD = 4'd0;
    localparam logic [3:0] OP_SUB = 4'd1;
    localparam logic [3:0] OP_AND = 4'd2;
    localparam logic [3:0] OP_ORR = 4'd3;
    localparam logic [3:0] OP_EOR = 4'd4;
    localparam logic [3:0] OP_MOV = 4'd5;
    localparam logic [3:0] OP_MVN = 4'd6;
    localparam logic [3:0] OP_CMP = 4'd7;
    localparam logic [3:0] OP_B   = 4'd8;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_EOR, ALU_PASS_B, ALU_NOT_B
    } alu_op_t;

    typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shift_op_t;

    // word addresses on adr[6:2]
    localparam logic [4:0] ADR_CMD      = 5'd0;
    localparam logic [4:0] ADR_STATUS   = 5'd1;
    localparam logic [4:0] ADR_PC       = 5'd2;
    localparam logic [4:0] ADR_REG_BASE = 5'd16;

endpackage

`default_nettype wire

//--- logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int PC_WIDTH = 11,
    parameter int START_PC = 0
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [3:0]          w_addr,
    input  wire logic [31:0]         w_data,
    input  wire logic                w_en,
    input  wire logic [3:0]          host_addr,
    input  wire logic [31:0]         host_w_data,
    input  wire logic                host_w_en,
    input  wire logic [3:0]          a_addr,
    input  wire logic [3:0]          b_addr,
    input  wire logic [3:0]          s_addr,
    output logic      [31:0]         a_data,
    output logic      [31:0]         b_data,
    output logic      [31:0]         s_data,
    output logic      [31:0]         host_r_data,
    output logic      [PC_WIDTH-1:0] pc,
    input  wire logic                load_branch,
    input  wire logic                step_pc,
    input  wire logic [PC_WIDTH-1:0] branch_target
);

    logic [31:0] regs [16];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (w_en) begin
                regs[w_addr] <= w_data;
            end
            if (host_w_en) begin
                regs[host_addr] <= host_w_data; // later assignment, host wins
            end
        end
    end

    // program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= PC_WIDTH'(START_PC);
        end else if (load_branch) begin
            pc <= branch_target;
        end else if (step_pc) begin
            pc <= pc + 1'b1;    // wraps at 2**PC_WIDTH
        end
    end

    assign a_data      = regs[a_addr];
    assign b_data      = regs[b_addr];
    assign s_data      = regs[s_addr];
    assign host_r_data = regs[host_addr];

endmodule

`default_nettype wire

//--- verif/exec_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_properties
    import exec_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       cyc,
    input wire logic       stb,
    input wire logic       we,
    input wire logic [6:0] adr,
    input wire logic       ack
);

    logic is_cmd;

    assign is_cmd = we && (adr[6:2] == ADR_CMD);

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack stayed high for more than one cycle");

    ack_with_stb: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
        else $error("ack raised without an active strobe");

    // strobe first seen three edges before a command ack
    cmd_ack_delay: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) && is_cmd |-> $past(stb, 3) && !$past(stb, 4))
        else $error("command ack not three cycles after stb");

    reg_ack_delay: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) && !is_cmd |-> $past(stb) && !$past(stb, 2))
        else $error("register access ack not one cycle after stb");

endmodule

`default_nettype wire

//--- verif/exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb
    import exec_pkg::*;
();

    localparam int PC_WIDTH = 11;
    localparam int START_PC = 0;
    localparam int TIMEOUT  = 20;   // cycles per ack wait

    logic        clk = 1'b0;
    logic        rst;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [6:0]  adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic [31:0] dat_r;
    logic        ack;

    int err_cnt     = 0;
    int timeout_cnt = 0;

    // reference model state
    logic [31:0]         m_regs [16];
    logic [3:0]          m_nzcv;
    logic [PC_WIDTH-1:0] m_pc;

    // command table with one entry per command
    logic [31:0]         tab_cmd    [$];
    logic [31:0]         tab_rd     [$];
    logic                tab_rd_chk [$];
    logic [3:0]          tab_nzcv   [$];
    logic [PC_WIDTH-1:0] tab_delta  [$];

    exec_core #(
        .PC_WIDTH (PC_WIDTH),
        .START_PC (START_PC)
    ) u_exec_core (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack)
    );

    bind exec_ctrl exec_core_properties u_exec_core_properties (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .ack   (ack)
    );

    always #4 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // one wishbone classic transfer
    // lat counts edges after the first strobe cycle
    task automatic transfer(input logic wr, input logic [4:0] word, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int lat);
        int n;
        n = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= {word, 2'b00};
        dat_w <= wdata;
        do begin
            @(posedge clk);
            n++;
        end while (!ack && n < TIMEOUT);
        if (!ack) begin
            timeout_cnt++;
            $display("no ack within %0d cycles on word %0d", TIMEOUT, word);
        end
        rdata = dat_r;  // valid with ack
        lat   = n - 1;
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    function automatic logic [31:0] make_cmd(input logic [3:0] op, input logic s,
                                             input logic i, input logic [3:0] rd,
                                             input logic [3:0] rn, input logic [3:0] rm,
                                             input logic [13:0] low);
        return {op, s, i, rd, rn, rm, low};
    endfunction

    // returns {carry, result}
    function automatic logic [32:0] shift_model(input logic [31:0] v, input logic [1:0] kind,
                                                input logic [4:0] amt, input logic cin);
        logic [32:0] t;
        logic [63:0] w;
        if (amt == 5'd0) begin
            return {cin, v};
        end
        case (kind)
            2'd0: begin
                t = {1'b0, v} << amt;
                return t;
            end
            2'd1: begin
                t = {v, 1'b0} >> amt;
                return {t[0], t[32:1]};
            end
            2'd2: begin
                t = $signed({v, 1'b0}) >>> amt;
                return {t[0], t[32:1]};
            end
            default: begin
                w = {v, v} >> amt;  // rotate right
                return {w[31], w[31:0]};
            end
        endcase
    endfunction

    function automatic void run_model(input logic [31:0] cmd);
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [32:0] sh;
        logic [32:0] wide;
        logic [4:0]  amt;
        logic        c;
        logic        v;
        op = cmd[31:28];
        if (op == OP_B) begin
            m_pc = m_pc + PC_WIDTH'({{18{cmd[13]}}, cmd[13:0]});
            return;
        end
        m_pc = m_pc + PC_WIDTH'(1);
        if (op > OP_CMP) begin
            return;     // no-op
        end
        a   = m_regs[cmd[21:18]];
        amt = cmd[11] ? m_regs[cmd[9:6]][4:0] : cmd[10:6];
        if (cmd[26]) begin
            sh = {m_nzcv[1], 18'd0, cmd[13:0]};     // immediate keeps C
        end else begin
            sh = shift_model(m_regs[cmd[17:14]], cmd[13:12], amt, m_nzcv[1]);
        end
        b = sh[31:0];
        c = sh[32];
        v = m_nzcv[0];
        case (op)
            OP_ADD: begin
                {c, r} = {1'b0, a} + {1'b0, b};
                wide   = {a[31], a} + {b[31], b};
                v      = wide[32] != wide[31];
            end
            OP_SUB, OP_CMP: begin
                r    = a - b;
                c    = a >= b;  // no borrow
                wide = {a[31], a} - {b[31], b};
                v    = wide[32] != wide[31];
            end
            OP_AND:  r = a & b;
            OP_ORR:  r = a | b;
            OP_EOR:  r = a ^ b;
            OP_MOV:  r = b;
            default: r = ~b;
        endcase
        if (op != OP_CMP) begin
            m_regs[cmd[25:22]] = r;
        end
        if (cmd[27] || op == OP_CMP) begin
            m_nzcv = {r[31], r == 32'd0, c, v};
        end
    endfunction

    function automatic void add_entry(input logic [31:0] cmd);
        logic [PC_WIDTH-1:0] pc_old;
        pc_old = m_pc;
        run_model(cmd);
        tab_cmd.push_back(cmd);
        tab_rd.push_back(m_regs[cmd[25:22]]);
        tab_rd_chk.push_back(cmd[31:28] <= OP_CMP);
        tab_nzcv.push_back(m_nzcv);
        tab_delta.push_back(m_pc - pc_old);
    endfunction

    initial begin
        logic [31:0]         rdata;
        logic [31:0]         pre [16];
        logic [31:0]         c0;
        logic [31:0]         c1;
        logic [PC_WIDTH-1:0] last_pc;
        logic [PC_WIDTH-1:0] delta;
        int                  lat;
        void'($urandom(9312));
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = 4'hf;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 16; i++) begin
            transfer(1'b0, ADR_REG_BASE + 5'(i), 32'd0, rdata, lat);
            check_value($sformatf("dat_r r%0d", i), rdata, 32'd0);
            check_value("ack latency", lat, 1);
        end
        transfer(1'b0, ADR_STATUS, 32'd0, rdata, lat);
        check_value("dat_r status", rdata, 32'd0);
        transfer(1'b0, ADR_PC, 32'd0, rdata, lat);
        check_value("dat_r pc", rdata, START_PC);

        // fixed values for flag and shift cases and random values elsewhere
        for (int i = 0; i < 16; i++) begin
            pre[i] = $urandom;
        end
        pre[7]  = 32'h7fff_ffff;
        pre[8]  = 32'd1;
        pre[9]  = 32'hffff_ffff;
        pre[10] = 32'h8000_0000;
        pre[11] = 32'd31;
        pre[12] = 32'd0;
        pre[13] = $urandom % 32;    // register shift amount
        for (int i = 0; i < 16; i++) begin
            transfer(1'b1, ADR_REG_BASE + 5'(i), pre[i], rdata, lat);
            transfer(1'b0, ADR_REG_BASE + 5'(i), 32'd0, rdata, lat);
            check_value($sformatf("dat_r r%0d", i), rdata, pre[i]);
            m_regs[i] = pre[i];
        end
        m_nzcv  = 4'd0;
        m_pc    = PC_WIDTH'(START_PC);
        last_pc = PC_WIDTH'(START_PC);

        for (int op = 0; op <= 6; op++) begin
            add_entry(make_cmd(4'(op), 1'b0, 1'b0, 4'd14, 4'(op + 1), 4'(op + 2), 14'd0));
            add_entry(make_cmd(4'(op), 1'b0, 1'b1, 4'd15, 4'(op + 1), 4'd0, 14'($urandom)));
        end
        for (int k = 0; k < 4; k++) begin
            add_entry(make_cmd(OP_MOV, 1'b1, 1'b0, 4'd14, 4'd0, 4'd1, {2'(k), 1'b0, 5'd0, 6'd0}));
            add_entry(make_cmd(OP_MOV, 1'b1, 1'b0, 4'd14, 4'd0, 4'd10, {2'(k), 1'b0, 5'd31, 6'd0}));
            add_entry(make_cmd(OP_MOV, 1'b1, 1'b0, 4'd15, 4'd0, 4'd2,
                               {2'(k), 1'b0, 5'($urandom), 6'd0}));
            add_entry(make_cmd(OP_MOV, 1'b1, 1'b0, 4'd14, 4'd0, 4'd10, {2'(k), 1'b1, 5'd11, 6'd0}));
            add_entry(make_cmd(OP_MOV, 1'b1, 1'b0, 4'd15, 4'd0, 4'd3, {2'(k), 1'b1, 5'd12, 6'd0}));
            add_entry(make_cmd(OP_ORR, 1'b0, 1'b0, 4'd14, 4'd5, 4'd4, {2'(k), 1'b1, 5'd13, 6'd0}));
        end
        add_entry(make_cmd(OP_SUB, 1'b1, 1'b0, 4'd14, 4'd1, 4'd1, 14'd0));   // zero
        add_entry(make_cmd(OP_SUB, 1'b1, 1'b0, 4'd15, 4'd12, 4'd8, 14'd0));  // 0 - 1 borrows
        add_entry(make_cmd(OP_ADD, 1'b1, 1'b0, 4'd14, 4'd9, 4'd8, 14'd0));   // carry out
        add_entry(make_cmd(OP_ADD, 1'b1, 1'b0, 4'd15, 4'd7, 4'd8, 14'd0));   // signed overflow
        add_entry(make_cmd(OP_SUB, 1'b1, 1'b0, 4'd14, 4'd10, 4'd8, 14'd0));
        add_entry(make_cmd(OP_ADD, 1'b0, 1'b0, 4'd15, 4'd9, 4'd9, 14'd0));   // flags hold
        add_entry(make_cmd(OP_CMP, 1'b0, 1'b0, 4'd14, 4'd7, 4'd10, 14'd0));
        add_entry(make_cmd(OP_CMP, 1'b0, 1'b1, 4'd14, 4'd8, 4'd0, 14'd1));
        // top bit shifted out lands in C
        add_entry(make_cmd(OP_AND, 1'b1, 1'b0, 4'd15, 4'd9, 4'd10, {2'd0, 1'b0, 5'd1, 6'd0}));
        add_entry(make_cmd(OP_ORR, 1'b1, 1'b1, 4'd14, 4'd12, 4'd0, 14'd0));
        add_entry(make_cmd(4'hf, 1'b0, 1'b0, 4'd14, 4'd1, 4'd2, 14'd0));     // no-op
        add_entry(make_cmd(OP_B, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, 14'd5));
        add_entry(make_cmd(OP_B, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, 14'h3ffd));   // -3
        add_entry(make_cmd(OP_B, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, 14'h2000));   // wraps low
        add_entry(make_cmd(OP_B, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, 14'h1fff));   // wraps high

        for (int i = 0; i < tab_cmd.size(); i++) begin
            transfer(1'b1, ADR_CMD, tab_cmd[i], rdata, lat);
            check_value("cmd ack latency", lat, 3);
            if (tab_rd_chk[i]) begin
                transfer(1'b0, ADR_REG_BASE + {1'b0, tab_cmd[i][25:22]}, 32'd0, rdata, lat);
                check_value($sformatf("dat_r r%0d", tab_cmd[i][25:22]), rdata, tab_rd[i]);
            end
            transfer(1'b0, ADR_STATUS, 32'd0, rdata, lat);
            check_value("dat_r status", rdata, {tab_nzcv[i], 28'd0});
            transfer(1'b0, ADR_PC, 32'd0, rdata, lat);
            delta = rdata[PC_WIDTH-1:0] - last_pc;
            check_value("pc delta", delta, tab_delta[i]);
            last_pc = rdata[PC_WIDTH-1:0];
        end

        // second command uses the first result with no gap
        c0 = make_cmd(OP_ADD, 1'b0, 1'b0, 4'd14, 4'd1, 4'd2, 14'd0);
        c1 = make_cmd(OP_EOR, 1'b0, 1'b0, 4'd15, 4'd14, 4'd3, 14'd0);
        run_model(c0);
        run_model(c1);
        transfer(1'b1, ADR_CMD, c0, rdata, lat);
        transfer(1'b1, ADR_CMD, c1, rdata, lat);
        check_value("cmd ack latency", lat, 3);

        for (int i = 0; i < 16; i++) begin
            transfer(1'b0, ADR_REG_BASE + 5'(i), 32'd0, rdata, lat);
            check_value($sformatf("dat_r r%0d", i), rdata, m_regs[i]);
        end
        transfer(1'b0, ADR_STATUS, 32'd0, rdata, lat);
        check_value("dat_r status", rdata, {m_nzcv, 28'd0});
        transfer(1'b0, ADR_PC, 32'd0, rdata, lat);
        check_value("dat_r pc", rdata, {21'd0, m_pc});

        $display("check errors: %0d, ack timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/exec_pkg.sv
logic/regfile.sv
logic/barrel_shifter.sv
logic/alu.sv
logic/datapath.sv
logic/exec_ctrl.sv
logic/exec_core.sv
verif/exec_core_properties.sv
verif/exec_core_tb.sv
